//--- source/tlb_pkg.sv
// ------------------------------
// Shared TLB definitions
// Page and offset widths, default entry count,
// attribute and entry structs
// ------------------------------

`default_nettype none

package tlb_pkg;

    // 4 KB pages in a 32-bit linear space
    localparam int PAGE_BITS   = 20;
    localparam int OFFSET_BITS = 12;

    localparam int DEFAULT_ENTRIES = 32;

    typedef logic [PAGE_BITS-1:0] page_t;

    // Page attributes returned with a translation
    typedef struct packed {
        logic combined_su;
        logic combined_rw;
        logic pcd;
        logic pwt;
    } tlb_attr_t;

    // One mapping, 46 bits
    typedef struct packed {
        logic      dirty;
        logic      valid;
        tlb_attr_t attr;
        page_t     physical;
        page_t     linear;
    } tlb_entry_t;

endpackage

`default_nettype wire

//--- source/tlb_bank_if.sv
// ------------------------------
// Entry bank bundle
// Per-entry vectors shared by the entry array,
// the fill block and the hit-select block
// ------------------------------

`default_nettype none

interface tlb_bank_if #(
    parameter int NUM_ENTRIES = tlb_pkg::DEFAULT_ENTRIES
);

    // Fill side
    logic [NUM_ENTRIES-1:0] write_en;
    tlb_pkg::tlb_entry_t    write_entry;

    // Hit-select side
    logic [NUM_ENTRIES-1:0] clean_inval;
    logic [NUM_ENTRIES-1:0] hit_onehot;

    // Entry state, one slot per entry
    logic [NUM_ENTRIES-1:0] valid;
    logic [NUM_ENTRIES-1:0] match;
    tlb_pkg::tlb_entry_t [NUM_ENTRIES-1:0] entries;

    modport fill (
        input  valid,
        input  hit_onehot,
        output write_en,
        output write_entry
    );

    modport select (
        input  match,
        input  entries,
        output hit_onehot,
        output clean_inval
    );

endinterface

`default_nettype wire

//--- source/tlb_entry.sv
// ------------------------------
// Single TLB entry
// Tag compare, flush and write of one mapping
// ------------------------------

`default_nettype none

module tlb_entry (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        write_en,
    input  wire tlb_pkg::tlb_entry_t   write_entry,
    input  wire                        lookup_do,
    input  wire tlb_pkg::page_t        lookup_page,
    input  wire                        flush_single,
    input  wire tlb_pkg::page_t        flush_page,
    input  wire                        flush_all,
    input  wire                        clean_inval,
    output logic                       valid,
    output logic                       match,
    output tlb_pkg::tlb_entry_t        entry
);

    logic                valid_q;
    tlb_pkg::tlb_entry_t data_q;
    logic                clear;

    // Any flush or a dirty-rule invalidate beats a write
    assign clear = flush_all || clean_inval ||
                   (flush_single && valid_q && (data_q.linear == flush_page));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (clear) begin
            valid_q <= 1'b0;
        end else if (write_en) begin
            valid_q <= write_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en && !clear) begin
            data_q <= write_entry;
        end
    end

    assign valid = valid_q;
    assign match = lookup_do && valid_q && (data_q.linear == lookup_page);

    always_comb begin
        entry       = data_q;
        entry.valid = valid_q;
    end

endmodule

`default_nettype wire

//--- source/tlb_fill_ctrl.sv
// ------------------------------
// Fill and replacement
// Free-entry search, tree pseudo-LRU,
// victim choice and write data
// ------------------------------

`default_nettype none

module tlb_fill_ctrl #(
    parameter int NUM_ENTRIES = tlb_pkg::DEFAULT_ENTRIES
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      fill,
    input  wire [31:0]               fill_linear,
    input  wire [31:0]               fill_physical,
    input  wire tlb_pkg::tlb_attr_t  fill_attr,
    input  wire                      rw,
    input  wire                      flush_all,
    tlb_bank_if.fill                 bank
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    // Heap-ordered tree, node n has children 2n+1 and 2n+2
    logic [NUM_ENTRIES-2:0] plru_q;
    logic [NUM_ENTRIES-2:0] plru_next;

    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] victim_idx;
    logic [IDX_W-1:0] fill_idx;
    logic [IDX_W-1:0] hit_idx;
    logic [IDX_W-1:0] touch_idx;
    logic             touch_en;

    // Lowest invalid entry
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!bank.valid[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    // Walk from the root, 0 goes to the lower half
    always_comb begin
        int unsigned node;
        node       = 0;
        victim_idx = '0;
        for (int l = 0; l < IDX_W; l++) begin
            victim_idx[IDX_W-1-l] = plru_q[node];
            node = 2 * node + 1 + int'(plru_q[node]);
        end
    end

    assign fill_idx = free_found ? free_idx : victim_idx;

    // Hit vector is already one-hot
    always_comb begin
        hit_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (bank.hit_onehot[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    // ------------------------------
    // Tree update
    // ------------------------------

    assign touch_en  = fill || (|bank.hit_onehot);
    assign touch_idx = fill ? fill_idx : hit_idx;

    // Point every node on the path away from the touched entry
    always_comb begin
        int unsigned node;
        logic        dir;
        plru_next = plru_q;
        node      = 0;
        for (int l = 0; l < IDX_W; l++) begin
            dir             = touch_idx[IDX_W-1-l];
            plru_next[node] = ~dir;
            node            = 2 * node + 1 + int'(dir);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            plru_q <= '0;
        end else if (flush_all) begin
            plru_q <= '0;
        end else if (touch_en) begin
            plru_q <= plru_next;
        end
    end

    // ------------------------------
    // Write strobe and data
    // ------------------------------

    always_comb begin
        bank.write_en = '0;
        if (fill) begin
            bank.write_en[fill_idx] = 1'b1;
        end
    end

    always_comb begin
        bank.write_entry.linear   = fill_linear[31:tlb_pkg::OFFSET_BITS];
        bank.write_entry.physical = fill_physical[31:tlb_pkg::OFFSET_BITS];
        bank.write_entry.attr     = fill_attr;
        bank.write_entry.valid    = 1'b1;
        // Write access on the fill marks the page dirty
        bank.write_entry.dirty    = rw;
    end

endmodule

`default_nettype wire

//--- source/tlb_hit_select.sv
// ------------------------------
// Hit selection
// Priority hit mux, translate outputs,
// dirty-rule invalidate
// ------------------------------

`default_nettype none

module tlb_hit_select #(
    parameter int NUM_ENTRIES = tlb_pkg::DEFAULT_ENTRIES
) (
    input  wire         rw,
    input  wire  [31:0] translate_linear,
    tlb_bank_if.select  bank,
    output logic        translate_valid,
    output logic [31:0] translate_physical,
    output logic        translate_pwt,
    output logic        translate_pcd,
    output logic        translate_combined_rw,
    output logic        translate_combined_su
);

    tlb_pkg::tlb_entry_t selected;
    logic                hit;
    logic                write_to_clean;

    // Lowest matching index wins
    always_comb begin
        selected        = '0;
        bank.hit_onehot = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (bank.match[i]) begin
                selected        = bank.entries[i];
                bank.hit_onehot = '0;
                bank.hit_onehot[i] = 1'b1;
            end
        end
    end

    assign hit = |bank.match;

    // Write to a clean page is a miss and drops the entry
    assign write_to_clean   = hit && rw && !selected.dirty;
    assign bank.clean_inval = write_to_clean ? bank.hit_onehot : '0;

    assign translate_valid    = hit && (!rw || selected.dirty);
    assign translate_physical = translate_valid ?
        {selected.physical, translate_linear[tlb_pkg::OFFSET_BITS-1:0]} : translate_linear;

    // Zero on a miss since selected is cleared
    assign translate_pwt         = selected.attr.pwt;
    assign translate_pcd         = selected.attr.pcd;
    assign translate_combined_rw = selected.attr.combined_rw;
    assign translate_combined_su = selected.attr.combined_su;

endmodule

`default_nettype wire

//--- source/tlb_top.sv
// ------------------------------
// TLB top level
// Entry array, fill control and hit select
// ------------------------------

`default_nettype none

module tlb_top #(
    parameter int NUM_ENTRIES = tlb_pkg::DEFAULT_ENTRIES
) (
    input  wire         clk,
    input  wire         rst_n,

    input  wire         flush_single,
    input  wire  [31:0] flush_address,
    input  wire         flush_all,

    input  wire         rw,

    input  wire         fill,
    input  wire  [31:0] fill_linear,
    input  wire  [31:0] fill_physical,
    input  wire         fill_pwt,
    input  wire         fill_pcd,
    input  wire         fill_combined_rw,
    input  wire         fill_combined_su,

    input  wire         translate_do,
    input  wire  [31:0] translate_linear,
    output logic        translate_valid,
    output logic [31:0] translate_physical,
    output logic        translate_pwt,
    output logic        translate_pcd,
    output logic        translate_combined_rw,
    output logic        translate_combined_su
);

    tlb_pkg::tlb_attr_t fill_attr;

    assign fill_attr = '{
        combined_su: fill_combined_su,
        combined_rw: fill_combined_rw,
        pcd:         fill_pcd,
        pwt:         fill_pwt
    };

    tlb_bank_if #(.NUM_ENTRIES(NUM_ENTRIES)) bank ();

    // ------------------------------
    // Entry array
    // ------------------------------

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
        tlb_entry u_entry (
            .clk          (clk),
            .rst_n        (rst_n),
            .write_en     (bank.write_en[i]),
            .write_entry  (bank.write_entry),
            .lookup_do    (translate_do),
            .lookup_page  (translate_linear[31:tlb_pkg::OFFSET_BITS]),
            .flush_single (flush_single),
            .flush_page   (flush_address[31:tlb_pkg::OFFSET_BITS]),
            .flush_all    (flush_all),
            .clean_inval  (bank.clean_inval[i]),
            .valid        (bank.valid[i]),
            .match        (bank.match[i]),
            .entry        (bank.entries[i])
        );
    end

    tlb_fill_ctrl #(.NUM_ENTRIES(NUM_ENTRIES)) u_fill_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .fill          (fill),
        .fill_linear   (fill_linear),
        .fill_physical (fill_physical),
        .fill_attr     (fill_attr),
        .rw            (rw),
        .flush_all     (flush_all),
        .bank          (bank.fill)
    );

    tlb_hit_select #(.NUM_ENTRIES(NUM_ENTRIES)) u_hit_select (
        .rw                    (rw),
        .translate_linear      (translate_linear),
        .bank                  (bank.select),
        .translate_valid       (translate_valid),
        .translate_physical    (translate_physical),
        .translate_pwt         (translate_pwt),
        .translate_pcd         (translate_pcd),
        .translate_combined_rw (translate_combined_rw),
        .translate_combined_su (translate_combined_su)
    );

endmodule

`default_nettype wire

//--- tb/tb_tlb_top.sv
// ------------------------------
// TLB testbench
// Clock, reset, LCG, reference model,
// directed and random stimulus, checks, watchdog
// ------------------------------

`default_nettype none

module tb_tlb_top;

    localparam int N             = tlb_pkg::DEFAULT_ENTRIES;
    localparam int IDX_W         = $clog2(N);
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 10;
    localparam int DIRECTED_OPS  = 4 * N + 64;
    localparam int RANDOM_OPS    = 2000;
    localparam int WATCHDOG_TIME =
        (RESET_CYCLES + DIRECTED_OPS + RANDOM_OPS + 100) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic        flush_single;
    logic [31:0] flush_address;
    logic        flush_all;
    logic        rw;
    logic        fill;
    logic [31:0] fill_linear;
    logic [31:0] fill_physical;
    logic        fill_pwt;
    logic        fill_pcd;
    logic        fill_combined_rw;
    logic        fill_combined_su;
    logic        translate_do;
    logic [31:0] translate_linear;
    logic        translate_valid;
    logic [31:0] translate_physical;
    logic        translate_pwt;
    logic        translate_pcd;
    logic        translate_combined_rw;
    logic        translate_combined_su;

    // Reference model of the entry array and PLRU tree
    logic [N-1:0] m_valid;
    logic [N-1:0] m_dirty;
    logic [19:0]  m_lin [N];
    logic [19:0]  m_phys [N];
    logic [3:0]   m_attr [N];
    logic [N-2:0] m_plru;
    logic [31:0]  lcg_state;

    tlb_top #(.NUM_ENTRIES(N)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    // Misses pass the linear address through
    miss_passthrough: assert property (@(negedge clk) disable iff (!rst_n)
        translate_valid || (translate_physical == translate_linear))
        else begin
            $display("[ERROR] translate_physical got 0x%08h expected 0x%08h",
                     translate_physical, translate_linear);
            stop_run();
        end

    // ------------------------------
    // Model helpers
    // ------------------------------

    // Lowest valid entry holding this page or -1
    function automatic int model_match(logic [19:0] page);
        for (int i = 0; i < N; i++) begin
            if (m_valid[i] && m_lin[i] == page) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int model_victim();
        int node;
        int v;
        node = 0;
        v    = 0;
        for (int l = 0; l < IDX_W; l++) begin
            v    = 2 * v + int'(m_plru[node]);
            node = 2 * node + 1 + int'(m_plru[node]);
        end
        return v;
    endfunction

    function automatic int model_fill_idx();
        for (int i = 0; i < N; i++) begin
            if (!m_valid[i]) begin
                return i;
            end
        end
        return model_victim();
    endfunction

    // Nodes on the path point away from the touched entry
    task automatic model_touch(int idx);
        int node;
        int dir;
        node = 0;
        for (int l = 0; l < IDX_W; l++) begin
            dir          = (idx >> (IDX_W - 1 - l)) & 1;
            m_plru[node] = (dir == 0);
            node         = 2 * node + 1 + dir;
        end
    endtask

    // Compare outputs mid-cycle and advance the model to the next edge
    task automatic check_cycle();
        int           hit_idx;
        int           fill_idx;
        logic         hit;
        logic         exp_valid;
        logic [3:0]   exp_attr;
        logic [31:0]  exp_phys;
        logic [N-1:0] clear;
        @(negedge clk);
        hit_idx   = translate_do ? model_match(translate_linear[31:12]) : -1;
        hit       = (hit_idx >= 0);
        exp_valid = hit && (!rw || m_dirty[hit_idx]);
        exp_attr  = hit ? m_attr[hit_idx] : 4'h0;
        exp_phys  = exp_valid ? {m_phys[hit_idx], translate_linear[11:0]} : translate_linear;
        check_value("translate_valid", 32'(translate_valid), 32'(exp_valid));
        check_value("translate_physical", translate_physical, exp_phys);
        check_value("translate_pwt", 32'(translate_pwt), 32'(exp_attr[0]));
        check_value("translate_pcd", 32'(translate_pcd), 32'(exp_attr[1]));
        check_value("translate_combined_rw", 32'(translate_combined_rw), 32'(exp_attr[2]));
        check_value("translate_combined_su", 32'(translate_combined_su), 32'(exp_attr[3]));
        fill_idx = model_fill_idx();
        for (int i = 0; i < N; i++) begin
            clear[i] = flush_all || (hit && rw && !m_dirty[hit_idx] && i == hit_idx) ||
                       (flush_single && m_valid[i] && m_lin[i] == flush_address[31:12]);
        end
        for (int i = 0; i < N; i++) begin
            if (clear[i]) begin
                m_valid[i] = 1'b0;
            end else if (fill && i == fill_idx) begin
                m_valid[i] = 1'b1;
                m_dirty[i] = rw;
                m_lin[i]   = fill_linear[31:12];
                m_phys[i]  = fill_physical[31:12];
                m_attr[i]  = {fill_combined_su, fill_combined_rw, fill_pcd, fill_pwt};
            end
        end
        if (flush_all) begin
            m_plru = '0;
        end else if (fill) begin
            model_touch(fill_idx);
        end else if (hit) begin
            model_touch(hit_idx);
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic drive(logic f, logic [31:0] f_lin, logic [31:0] f_phys, logic [3:0] attr,
                         logic t, logic [31:0] t_lin, logic acc_rw,
                         logic fs, logic [31:0] fs_addr, logic fa);
        @(posedge clk);
        fill             <= f;
        fill_linear      <= f_lin;
        fill_physical    <= f_phys;
        fill_pwt         <= attr[0];
        fill_pcd         <= attr[1];
        fill_combined_rw <= attr[2];
        fill_combined_su <= attr[3];
        translate_do     <= t;
        translate_linear <= t_lin;
        rw               <= acc_rw;
        flush_single     <= fs;
        flush_address    <= fs_addr;
        flush_all        <= fa;
        check_cycle();
    endtask

    task automatic fill_page(logic [31:0] lin, logic [31:0] phys, logic [3:0] attr,
                             logic acc_rw);
        drive(1'b1, lin, phys, attr, 1'b0, 32'h0, acc_rw, 1'b0, 32'h0, 1'b0);
    endtask

    // Lookup and check the expected hit or miss
    task automatic lookup_expect(logic [31:0] lin, logic acc_rw, logic exp_hit);
        drive(1'b0, 32'h0, 32'h0, 4'h0, 1'b1, lin, acc_rw, 1'b0, 32'h0, 1'b0);
        check_value("translate_valid", 32'(translate_valid), 32'(exp_hit));
    endtask

    task automatic flush_page(logic [31:0] addr);
        drive(1'b0, 32'h0, 32'h0, 4'h0, 1'b0, 32'h0, 1'b0, 1'b1, addr, 1'b0);
    endtask

    task automatic flush_everything();
        drive(1'b0, 32'h0, 32'h0, 4'h0, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0, 1'b1);
    endtask

    function automatic logic [31:0] seq_page(int i);
        return {20'(32'h200 + i), 12'h000};
    endfunction

    // Start empty and fill every entry in order
    task automatic fill_all_pages();
        flush_everything();
        for (int i = 0; i < N; i++) begin
            fill_page(seq_page(i), seq_page(i) ^ 32'h8000_0000, 4'h0, 1'b0);
        end
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish in %0d time units", WATCHDOG_TIME);
        stop_run();
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] f_lin;
        logic [31:0] t_lin;
        int          victim;
        lcg_state        = 32'd7634;
        rst_n            = 1'b0;
        flush_single     = 1'b0;
        flush_address    = 32'h0;
        flush_all        = 1'b0;
        rw               = 1'b0;
        fill             = 1'b0;
        fill_linear      = 32'h0;
        fill_physical    = 32'h0;
        fill_pwt         = 1'b0;
        fill_pcd         = 1'b0;
        fill_combined_rw = 1'b0;
        fill_combined_su = 1'b0;
        translate_do     = 1'b0;
        translate_linear = 32'h0;
        m_valid          = '0;
        m_plru           = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Empty buffer misses
        lookup_expect(32'h1234_5678, 1'b0, 1'b0);
        check_value("translate_physical", translate_physical, 32'h1234_5678);

        // Fill then read hit
        fill_page(32'h0040_1000, 32'h8765_4000, 4'b1010, 1'b0);
        lookup_expect(32'h0040_1abc, 1'b0, 1'b1);
        check_value("translate_physical", translate_physical, 32'h8765_4abc);

        // Dirty rule
        fill_page(32'h0040_3000, 32'h1111_1000, 4'b0101, 1'b0);
        lookup_expect(32'h0040_3010, 1'b1, 1'b0);
        lookup_expect(32'h0040_3010, 1'b0, 1'b0);
        fill_page(32'h0040_2000, 32'h2222_2000, 4'b1111, 1'b1);
        lookup_expect(32'h0040_2020, 1'b1, 1'b1);

        // Flushes
        flush_page(32'h0040_1000);
        lookup_expect(32'h0040_1abc, 1'b0, 1'b0);
        lookup_expect(32'h0040_2020, 1'b0, 1'b1);
        flush_everything();
        lookup_expect(32'h0040_2020, 1'b0, 1'b0);

        // Full buffer evicts the oldest page
        fill_all_pages();
        fill_page(32'h00F0_0000, 32'h00F0_0000, 4'h0, 1'b0);
        lookup_expect(seq_page(0), 1'b0, 1'b0);
        for (int i = 1; i < N; i++) begin
            lookup_expect(seq_page(i), 1'b0, 1'b1);
        end
        lookup_expect(32'h00F0_0000, 1'b0, 1'b1);

        // Touching the first page moves the victim elsewhere
        fill_all_pages();
        lookup_expect(seq_page(0), 1'b0, 1'b1);
        victim = model_victim();
        fill_page(32'h00F0_0000, 32'h00F0_0000, 4'h0, 1'b0);
        lookup_expect(seq_page(victim), 1'b0, 1'b0);
        lookup_expect(seq_page(0), 1'b0, 1'b1);

        // Random mix over a small page pool
        for (int k = 0; k < RANDOM_OPS; k++) begin
            r     = next_rand();
            a     = next_rand();
            b     = next_rand();
            f_lin = {20'h00100 + 20'((a >> 16) % 32'd48), a[11:0]};
            t_lin = {20'h00100 + 20'((b >> 16) % 32'd48), b[11:0]};
            drive(r[31:29] < 3'd3, f_lin, a ^ b, r[14:11], r[28:27] != 2'b00, t_lin,
                  r[26], r[25:22] == 4'h0, f_lin, r[21:15] == 7'h0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tlb_top.f
source/tlb_pkg.sv
source/tlb_bank_if.sv
source/tlb_entry.sv
source/tlb_fill_ctrl.sv
source/tlb_hit_select.sv
source/tlb_top.sv
tb/tb_tlb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the TLB testbench with Verilator and run it.
# The exit status of the simulation is the result of the run.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_tlb_top \
    -f tlb_top.f \
    -o tb_tlb_top

./obj_dir/tb_tlb_top
